/* uart_rx_pkg.sv */
package uart_rx_pkg;

    localparam int RX_DATA_WIDTH  = 8;  // data bits per frame
    localparam int RX_STATE_WIDTH = 4;  // enough for idle through stop

    // frame states, one per bit period
    typedef enum logic [RX_STATE_WIDTH-1:0] {
        RX_IDLE       = 4'b0000,
        RX_START_BIT  = 4'b0001,
        RX_DATA_BIT_0 = 4'b0010,  // lsb first on the line
        RX_DATA_BIT_1 = 4'b0011,
        RX_DATA_BIT_2 = 4'b0100,
        RX_DATA_BIT_3 = 4'b0101,
        RX_DATA_BIT_4 = 4'b0110,
        RX_DATA_BIT_5 = 4'b0111,
        RX_DATA_BIT_6 = 4'b1000,
        RX_DATA_BIT_7 = 4'b1001,  // last data bit
        RX_PARITY_BIT = 4'b1010,  // skipped when parity is off
        RX_STOP_BIT   = 4'b1011
    } rx_state_t;

    typedef logic [RX_DATA_WIDTH-1:0] rx_byte_t;

    // one fifo entry
    typedef struct packed {
        logic     parity_err;  // sampled parity bit disagreed
        rx_byte_t data;
    } rx_word_t;

endpackage

/* rx_ctrl_if.sv */
`timescale 1ns/1ps

interface rx_ctrl_if import uart_rx_pkg::*; ();

    logic      strobe;             // one pulse per bit, near mid-bit
    rx_state_t state;              // current frame state
    logic      data_is_available;  // registered, in a data state
    logic      data_is_valid;      // one pulse after last payload bit
    logic      is_parity_stage;    // decoded from state

    // baud generator needs idle to realign on a start edge
    modport baud (
        input  state,
        output strobe
    );

    modport fsm (
        input  strobe,
        output state, data_is_available, data_is_valid, is_parity_stage
    );

    modport deser (
        input  strobe, state, data_is_available, data_is_valid, is_parity_stage
    );

endinterface

/* rx_line_sync.sv */
`timescale 1ns/1ps

module rx_line_sync (
    input  logic clk,
    input  logic reset,
    input  logic rx,              // async serial line
    output logic rx_bit,          // synchronized line
    output logic start_detected   // one pulse per falling edge
);

    logic sync_1_q;  // may go metastable
    logic sync_2_q;  // settled copy
    logic line_q;    // previous settled value

    assign rx_bit = sync_2_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            sync_1_q       <= 1'b1;  // line idles high
            sync_2_q       <= 1'b1;
            line_q         <= 1'b1;
            start_detected <= 1'b0;
        end else begin
            sync_1_q       <= rx;
            sync_2_q       <= sync_1_q;
            line_q         <= sync_2_q;
            start_detected <= line_q & ~sync_2_q;  // high then low
        end
    end

    // every falling edge is flagged, data bits included
    // the fsm and the baud generator only act on it while idle

endmodule

/* rx_baud_gen.sv */
`timescale 1ns/1ps

module rx_baud_gen import uart_rx_pkg::*; #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic    clk,
    input  logic    reset,
    input  logic    start_detected,
    rx_ctrl_if.baud ctrl
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);

    // full period between strobes
    localparam logic [CNT_W-1:0] FULL_RELOAD = CNT_W'(CLKS_PER_BIT - 1);
    // first strobe lands half a period after the start pulse
    localparam logic [CNT_W-1:0] HALF_RELOAD = CNT_W'(CLKS_PER_BIT / 2 - 2);

    logic [CNT_W-1:0] count_q;
    logic             strobe_q;

    assign ctrl.strobe = strobe_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            count_q  <= FULL_RELOAD;
            strobe_q <= 1'b0;
        end else if (start_detected && (ctrl.state == RX_IDLE)) begin
            count_q  <= HALF_RELOAD;  // realign to the start edge
            strobe_q <= 1'b0;
        end else if (count_q == '0) begin
            count_q  <= FULL_RELOAD;
            strobe_q <= (ctrl.state != RX_IDLE);  // quiet between frames
        end else begin
            count_q  <= count_q - 1'b1;
            strobe_q <= 1'b0;
        end
    end

endmodule

/* rx_state.sv */
`timescale 1ns/1ps

module rx_state import uart_rx_pkg::*; #(
    parameter bit PARITY_ENABLED = 1'b1
) (
    input  logic   clk,
    input  logic   reset,
    input  logic   start_detected,
    rx_ctrl_if.fsm ctrl
);

    // state whose strobe completes the payload
    localparam rx_state_t LAST_PAYLOAD = PARITY_ENABLED ? RX_PARITY_BIT : RX_DATA_BIT_7;

    rx_state_t state_q;
    logic      data_available_q;
    logic      data_valid_q;

    assign ctrl.state             = state_q;
    assign ctrl.data_is_available = data_available_q;
    assign ctrl.data_is_valid     = data_valid_q;
    assign ctrl.is_parity_stage   = (state_q == RX_PARITY_BIT);  // plain decode

    always_ff @(posedge clk) begin
        if (reset) begin
            data_valid_q     <= 1'b0;
            data_available_q <= 1'b0;
        end else begin
            // single pulse so the consumer sees each byte once
            data_valid_q     <= ctrl.strobe && (state_q == LAST_PAYLOAD);
            data_available_q <= (state_q >= RX_DATA_BIT_0) && (state_q <= RX_DATA_BIT_7);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= RX_IDLE;
        end else if (ctrl.strobe) begin
            case (state_q)
                RX_IDLE: begin
                    if (start_detected) begin
                        state_q <= RX_START_BIT;
                    end
                end
                RX_START_BIT:  state_q <= RX_DATA_BIT_0;  // start bit not re-checked
                RX_DATA_BIT_0,
                RX_DATA_BIT_1,
                RX_DATA_BIT_2,
                RX_DATA_BIT_3,
                RX_DATA_BIT_4,
                RX_DATA_BIT_5,
                RX_DATA_BIT_6: state_q <= rx_state_t'(state_q + 1'b1);  // next data bit
                RX_DATA_BIT_7: state_q <= PARITY_ENABLED ? RX_PARITY_BIT : RX_STOP_BIT;
                RX_PARITY_BIT: state_q <= RX_STOP_BIT;
                RX_STOP_BIT:   state_q <= RX_IDLE;  // stop level not checked
                default:       state_q <= RX_IDLE;
            endcase
        end else if ((state_q == RX_IDLE) && start_detected) begin
            state_q <= RX_START_BIT;  // start edge taken on any cycle
        end
    end

endmodule

/* rx_deserializer.sv */
`timescale 1ns/1ps

module rx_deserializer import uart_rx_pkg::*; #(
    parameter bit PARITY_ENABLED = 1'b1,
    parameter bit PARITY_ODD     = 1'b0
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     rx_bit,
    rx_ctrl_if.deser ctrl,
    output rx_word_t word,
    output logic     push
);

    rx_byte_t shift_q;       // assembled byte
    logic     parity_acc_q;  // expected parity bit so far
    logic     parity_err_q;
    logic     sample_data;
    logic     sample_parity;

    assign sample_data   = ctrl.strobe && ctrl.data_is_available;
    assign sample_parity = ctrl.strobe && ctrl.is_parity_stage;

    // lsb arrives first, so shift in from the top
    always_ff @(posedge clk) begin
        if (sample_data) begin
            shift_q <= {rx_bit, shift_q[RX_DATA_WIDTH-1:1]};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            parity_acc_q <= 1'b0;
            parity_err_q <= 1'b0;
        end else begin
            if (ctrl.state == RX_START_BIT) begin
                parity_acc_q <= PARITY_ODD;  // odd parity starts inverted
            end else if (sample_data) begin
                parity_acc_q <= parity_acc_q ^ rx_bit;
            end
            if (sample_parity) begin
                parity_err_q <= rx_bit ^ parity_acc_q;  // mismatch
            end
        end
    end

    assign word.data       = shift_q;
    assign word.parity_err = PARITY_ENABLED & parity_err_q;  // 0 without parity
    assign push            = ctrl.data_is_valid;  // byte and flag settled by now

endmodule

/* rx_credit_fifo.sv */
`timescale 1ns/1ps

module rx_credit_fifo import uart_rx_pkg::*; #(
    parameter int FIFO_DEPTH = 4,
    parameter int CREDITS    = 2
) (
    input  logic     clk,
    input  logic     reset,
    input  rx_word_t word,
    input  logic     push,
    input  logic     credit_return,  // one pulse per freed slot downstream
    output rx_word_t out_word,
    output logic     out_valid,
    output logic     overrun         // sticky until reset
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
    localparam int CRD_W = $clog2(CREDITS + 1);

    localparam logic [PTR_W-1:0] LAST_PTR    = PTR_W'(FIFO_DEPTH - 1);
    localparam logic [CNT_W-1:0] FULL_COUNT  = CNT_W'(FIFO_DEPTH);
    localparam logic [CRD_W-1:0] MAX_CREDITS = CRD_W'(CREDITS);

    rx_word_t         mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] fill_q;
    logic [CRD_W-1:0] credit_q;
    logic             pop;
    logic             accept;

    assign pop    = (fill_q != '0) && (credit_q != '0);  // data and a credit
    assign accept = push && ((fill_q != FULL_COUNT) || pop);  // full slot may free now

    always_ff @(posedge clk) begin
        if (accept) begin
            mem[wr_ptr_q] <= word;
        end
        if (pop) begin
            out_word <= mem[rd_ptr_q];  // qualified by out_valid
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr_q  <= '0;
            rd_ptr_q  <= '0;
            fill_q    <= '0;
            credit_q  <= MAX_CREDITS;  // consumer starts with all slots free
            out_valid <= 1'b0;
            overrun   <= 1'b0;
        end else begin
            out_valid <= pop;
            if (accept) begin
                wr_ptr_q <= (wr_ptr_q == LAST_PTR) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == LAST_PTR) ? '0 : rd_ptr_q + 1'b1;
            end
            if (accept && !pop) begin
                fill_q <= fill_q + 1'b1;
            end else if (pop && !accept) begin
                fill_q <= fill_q - 1'b1;
            end
            // spend and return together cancel out
            if (pop && !credit_return) begin
                credit_q <= credit_q - 1'b1;
            end else if (credit_return && !pop && (credit_q != MAX_CREDITS)) begin
                credit_q <= credit_q + 1'b1;
            end
            if (push && !accept) begin
                overrun <= 1'b1;  // word dropped
            end
        end
    end

endmodule

/* uart_rx_top.sv */
`timescale 1ns/1ps

module uart_rx_top import uart_rx_pkg::*; #(
    parameter int CLKS_PER_BIT   = 16,
    parameter bit PARITY_ENABLED = 1'b1,
    parameter bit PARITY_ODD     = 1'b0,
    parameter int FIFO_DEPTH     = 4,
    parameter int CREDITS        = 2
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     rx,
    input  logic     credit_return,
    output rx_byte_t out_byte,
    output logic     out_parity_err,
    output logic     out_valid,
    output logic     overrun
);

    logic     rx_bit;
    logic     start_detected;
    rx_word_t word;       // deserializer to fifo
    logic     push;
    rx_word_t out_word;   // fifo output entry

    rx_ctrl_if ctrl ();   // strobe and stage flags

    rx_line_sync u_line_sync (
        .clk            (clk),
        .reset          (reset),
        .rx             (rx),
        .rx_bit         (rx_bit),
        .start_detected (start_detected)
    );

    rx_baud_gen #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_baud_gen (
        .clk            (clk),
        .reset          (reset),
        .start_detected (start_detected),
        .ctrl           (ctrl.baud)
    );

    rx_state #(.PARITY_ENABLED(PARITY_ENABLED)) u_state (
        .clk            (clk),
        .reset          (reset),
        .start_detected (start_detected),
        .ctrl           (ctrl.fsm)
    );

    rx_deserializer #(
        .PARITY_ENABLED (PARITY_ENABLED),
        .PARITY_ODD     (PARITY_ODD)
    ) u_deserializer (
        .clk    (clk),
        .reset  (reset),
        .rx_bit (rx_bit),
        .ctrl   (ctrl.deser),
        .word   (word),
        .push   (push)
    );

    rx_credit_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .CREDITS    (CREDITS)
    ) u_fifo (
        .clk           (clk),
        .reset         (reset),
        .word          (word),
        .push          (push),
        .credit_return (credit_return),
        .out_word      (out_word),
        .out_valid     (out_valid),
        .overrun       (overrun)
    );

    assign out_byte       = out_word.data;
    assign out_parity_err = out_word.parity_err;

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 2,   // 4 ns clock
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;  // released on an edge like other stimulus
    end

endmodule

/* tb_uart_rx.sv */
`timescale 1ns/1ps

module tb_uart_rx;

    localparam int CLKS_PER_BIT = 16;
    localparam int FIFO_DEPTH   = 4;
    localparam int CREDITS      = 2;
    localparam int HELD_LIMIT   = FIFO_DEPTH + CREDITS;  // bytes that survive a hold
    localparam int NUM_ROWS     = 16;
    localparam int TIMEOUT_NS   = NUM_ROWS * 12 * CLKS_PER_BIT * 4 + 2000;

    // {data, bad parity, hold credits}
    localparam logic [9:0] ROWS [NUM_ROWS] = '{
        {8'h00, 1'b0, 1'b0}, {8'hff, 1'b0, 1'b0}, {8'h55, 1'b0, 1'b0}, {8'haa, 1'b0, 1'b0},
        {8'ha5, 1'b1, 1'b0}, {8'h3c, 1'b0, 1'b0}, {8'h81, 1'b1, 1'b0},
        {8'h12, 1'b0, 1'b1}, {8'h34, 1'b0, 1'b1}, {8'h56, 1'b0, 1'b1}, {8'h78, 1'b1, 1'b1},
        {8'h9a, 1'b0, 1'b1}, {8'hbc, 1'b0, 1'b1}, {8'hde, 1'b0, 1'b1},  // last one dropped
        {8'hf0, 1'b0, 1'b0}, {8'h0f, 1'b1, 1'b0}
    };

    logic        clk;
    logic        reset;
    logic        rx = 1'b1;             // line idles high
    logic        credit_return = 1'b0;
    logic [7:0]  out_byte;
    logic        out_parity_err;
    logic        out_valid;
    logic        overrun;

    logic [8:0]  exp_q [$];             // {parity_err, byte} in send order
    int          due_q [$];             // cycles at which credits go back
    logic [8:0]  expected_word;
    logic        hold_credits = 1'b0;
    logic [31:0] rnd_state = 32'd91;
    int          outstanding = 0;       // valids not yet paid back
    int          cycle_count = 0;
    int          last_due = 0;
    int          next_due;

    tb_clock_gen clock_gen (.clk(clk), .reset(reset));

    uart_rx_top #(
        .CLKS_PER_BIT   (CLKS_PER_BIT),
        .PARITY_ENABLED (1'b1),
        .PARITY_ODD     (1'b0),
        .FIFO_DEPTH     (FIFO_DEPTH),
        .CREDITS        (CREDITS)
    ) dut (
        .clk            (clk),
        .reset          (reset),
        .rx             (rx),
        .credit_return  (credit_return),
        .out_byte       (out_byte),
        .out_parity_err (out_parity_err),
        .out_valid      (out_valid),
        .overrun        (overrun)
    );

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic stop_with_failure();
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Mismatch at %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
            stop_with_failure();
        end
    endtask

    // start, 8 data bits lsb first, parity, stop
    task automatic send_frame(input logic [7:0] data, input logic parity_bit);
        logic [10:0] bits;
        bits = {1'b1, parity_bit, data, 1'b0};
        for (int b = 0; b < 11; b++) begin
            @(posedge clk);
            rx <= bits[b];
            repeat (CLKS_PER_BIT - 1) @(posedge clk);  // one bit period
        end
    endtask

    // consumer hands back one credit per cycle once due
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (!hold_credits && (due_q.size() > 0) && (due_q[0] <= cycle_count)) begin
            credit_return <= 1'b1;
            void'(due_q.pop_front());
        end else begin
            credit_return <= 1'b0;
        end
    end

    // monitor samples mid-cycle
    always @(negedge clk) begin
        if (!reset && out_valid && (exp_q.size() == 0)) begin
            $display("Error at %0t ns: a byte arrived that was never sent", $time);
            stop_with_failure();
        end else if (!reset) begin
            if (out_valid) begin
                expected_word = exp_q.pop_front();
                check_value("out_byte", 32'(out_byte), 32'(expected_word[7:0]));
                check_value("out_parity_err", 32'(out_parity_err), 32'(expected_word[8]));
                outstanding = outstanding + 1;
                rnd_state   = next_random(rnd_state);
                next_due    = cycle_count + 1 + int'(rnd_state[2:0]);  // 1 to 8 cycles
                if (next_due <= last_due) begin
                    next_due = last_due + 1;  // keep the queue in order
                end
                last_due = next_due;
                due_q.push_back(next_due);
            end
            if (credit_return) begin
                outstanding = outstanding - 1;
            end
            if (outstanding > CREDITS) begin
                $display("Error at %0t ns: %0d bytes out without credit", $time, outstanding);
                stop_with_failure();
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Error: timeout after %0d ns, bytes stopped arriving", TIMEOUT_NS);
        stop_with_failure();
    end

    initial begin
        logic [9:0] row;
        logic [7:0] data;
        logic       parity_bit;
        logic       parity_err;
        logic       in_hold;
        int         held_sent;
        in_hold    = 1'b0;
        held_sent  = 0;
        while (reset !== 1'b0) @(posedge clk);
        @(negedge clk);
        check_value("out_valid", 32'(out_valid), 32'd0);
        check_value("overrun", 32'(overrun), 32'd0);
        repeat (40) @(negedge clk);  // idle line, nothing may arrive
        for (int i = 0; i < NUM_ROWS; i++) begin
            row = ROWS[i];
            @(negedge clk);
            if (row[0] && !in_hold) begin
                // start the hold with every credit back home
                while ((exp_q.size() != 0) || (outstanding != 0)) @(negedge clk);
                check_value("overrun", 32'(overrun), 32'd0);
            end
            if (!row[0] && in_hold) begin
                check_value("overrun", 32'(overrun), 32'd1);
            end
            in_hold      = row[0];
            hold_credits = row[0];
            data         = row[9:2];
            parity_bit   = (^data) ^ row[1];  // even parity, flipped when bad
            parity_err   = row[1];            // flagged exactly for flipped rows
            if (!row[0] || (held_sent < HELD_LIMIT)) begin
                exp_q.push_back({parity_err, data});
            end
            if (row[0]) begin
                held_sent = held_sent + 1;
            end
            send_frame(data, parity_bit);
        end
        @(negedge clk);
        hold_credits = 1'b0;
        while (exp_q.size() != 0) @(negedge clk);
        repeat (20) @(negedge clk);  // catch stray bytes
        check_value("overrun", 32'(overrun), 32'd1);
        $display("Result: PASSED");
        $finish;
    end

endmodule

/* src.f */
uart_rx_pkg.sv
rx_ctrl_if.sv
rx_line_sync.sv
rx_baud_gen.sv
rx_state.sv
rx_deserializer.sv
rx_credit_fifo.sv
uart_rx_top.sv
tb_clock_gen.sv
tb_uart_rx.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --top-module tb_uart_rx -f src.f -o tb_uart_rx
	./obj_dir/tb_uart_rx > sim.log 2>&1; cat sim.log
	grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
